/* rtl/mpi_pkg.sv */
////////////////////////////////////////
// MPI endpoint shared definitions
// Widths, register slots, control flit
// fields and the size counter helper
////////////////////////////////////////

package mpi_pkg;

  // Flit and bus data width
  localparam int flit_w = 32;

  typedef logic [flit_w-1:0] flit_t;
  typedef logic [31:0]       bus_addr_t;

  // Register slot, decoded from address bits 5:2
  typedef enum logic [1:0] {
    sel_fifo,
    sel_ctrl,
    sel_other
  } reg_sel_t;

  ////////////////////////////////////////
  // Control message layout
  ////////////////////////////////////////

  // Class field 26:24 marks a control message
  localparam logic [2:0] ctrl_class     = 3'b111;
  localparam int         ctrl_class_lsb = 24;
  // Source 31:27, destination 23:19
  localparam int         ctrl_src_lsb   = 27;
  localparam int         ctrl_dst_lsb   = 19;
  // Set in a reply, clear in a request
  localparam int         ctrl_reply_bit  = 0;
  // Enable state carried back in a reply
  localparam int         ctrl_enable_bit = 1;

  // Counter width able to hold 0..depth, never below 1
  function automatic int size_w_f(input int depth);
    int w;
    w = $clog2(depth + 1);
    return (w < 1) ? 1 : w;
  endfunction

endpackage

/* rtl/noc_flit_if.sv */
////////////////////////////////////////
// NoC flit stream
// Valid/ready link with a last marker
////////////////////////////////////////

`timescale 1ns/10ps

interface noc_flit_if;
  import mpi_pkg::*;

  flit_t flit;
  logic  last;
  logic  valid;
  logic  ready;

  // Source holds flit and last while valid waits for ready
  modport source (output flit, output last, output valid, input ready);

  modport sink (input flit, input last, input valid, output ready);

endinterface

/* rtl/mpi_packet_buffer.sv */
////////////////////////////////////////
// Full-packet flit buffer
// Releases a packet only once all of it
// is stored, reports head packet size
////////////////////////////////////////

`timescale 1ns/10ps

module mpi_packet_buffer #(
  parameter int buf_depth = 16
) (
  input  logic                                    clk,
  input  logic                                    rst,
  noc_flit_if.sink                                fill,
  noc_flit_if.source                              drain,
  output logic [mpi_pkg::size_w_f(buf_depth)-1:0] packet_size
);
  import mpi_pkg::*;

  localparam int               size_w    = size_w_f(buf_depth);
  localparam int               ptr_w     = size_w_f(buf_depth - 1);
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(buf_depth - 1);

  // Flit store and the matching last markers
  flit_t                 mem [buf_depth];
  logic [buf_depth-1:0]  last_mem;

  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  // Flits stored, and complete packets stored
  logic [size_w-1:0] fill_count;
  logic [size_w-1:0] pkt_count;

  logic push;
  logic pop;

  assign push = fill.valid && fill.ready;
  assign pop  = drain.valid && drain.ready;

  assign fill.ready  = (fill_count != size_w'(buf_depth));
  // Head is only offered once a whole packet sits in the store
  assign drain.valid = (pkt_count != '0);
  assign drain.flit  = mem[rd_ptr];
  assign drain.last  = last_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr]      <= fill.flit;
      last_mem[wr_ptr] <= fill.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
      pkt_count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
      // Packet boundaries in and out
      case ({push && fill.last, pop && drain.last})
        2'b10:   pkt_count <= pkt_count + 1'b1;
        2'b01:   pkt_count <= pkt_count - 1'b1;
        default: pkt_count <= pkt_count;
      endcase
    end
  end

  // Head packet size, scanning from the read pointer to the first last marker
  always_comb begin
    int   idx;
    logic found;
    packet_size = '0;
    found       = 1'b0;
    for (int i = 0; i < buf_depth; i++) begin
      idx = int'(rd_ptr) + i;
      if (idx >= buf_depth) begin
        idx = idx - buf_depth;
      end
      if (!found && (i < int'(fill_count))) begin
        packet_size = size_w'(i + 1);
        found       = last_mem[idx];
      end
    end
    // Partial packet only, nothing to report
    if (pkt_count == '0) begin
      packet_size = '0;
    end
  end

endmodule

/* rtl/mpi_bus_regs.sv */
////////////////////////////////////////
// MPI bus register block
// Address decode, enable bit, status
// and error response
////////////////////////////////////////

`timescale 1ns/10ps

module mpi_bus_regs (
  input  logic               clk,
  input  logic               rst,
  input  mpi_pkg::bus_addr_t bus_addr,
  input  logic               bus_we,
  input  logic               bus_en,
  output mpi_pkg::flit_t     bus_data_out,
  output logic               bus_ack,
  output logic               bus_err,
  output logic               fifo_rd_en,
  output logic               fifo_wr_en,
  input  logic               rd_ack,
  input  mpi_pkg::flit_t     rd_data,
  input  logic               wr_ack,
  input  logic               tx_busy,
  input  logic               rx_avail,
  output logic               enabled
);
  import mpi_pkg::*;

  reg_sel_t sel;

  // Slot from word address bits 5:2
  always_comb begin
    case (bus_addr[5:2])
      4'h0:    sel = sel_fifo;
      4'h1:    sel = sel_ctrl;
      default: sel = sel_other;
    endcase
  end

  always_comb begin
    bus_ack      = 1'b0;
    bus_err      = 1'b0;
    bus_data_out = '0;
    fifo_rd_en   = 1'b0;
    fifo_wr_en   = 1'b0;
    if (bus_en) begin
      case (sel)
        sel_fifo: begin
          // Reads go to the ingress reader, writes to the egress framer
          fifo_rd_en   = !bus_we;
          fifo_wr_en   = bus_we;
          bus_ack      = bus_we ? wr_ack : rd_ack;
          bus_data_out = bus_we ? '0 : rd_data;
        end
        sel_ctrl: begin
          bus_ack = 1'b1;
          if (!bus_we) begin
            bus_data_out = {{(flit_w - 2){1'b0}}, tx_busy, rx_avail};
          end
        end
        default: bus_err = 1'b1;
      endcase
    end
  end

  // Enable is sticky once written
  always_ff @(posedge clk) begin
    if (rst) begin
      enabled <= 1'b0;
    end else if (bus_en && bus_we && (sel == sel_ctrl)) begin
      enabled <= 1'b1;
    end
  end

endmodule

/* rtl/mpi_tx_framer.sv */
////////////////////////////////////////
// Egress framer
// Size word first, then that many flits
// pushed into the egress buffer
////////////////////////////////////////

`timescale 1ns/10ps

module mpi_tx_framer #(
  parameter int buf_depth = 16
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr_en,
  input  mpi_pkg::flit_t wr_data,
  output logic           wr_ack,
  noc_flit_if.source     fill
);
  import mpi_pkg::*;

  localparam int size_w = size_w_f(buf_depth);

  typedef enum logic [1:0] {
    tx_idle,
    tx_first,
    tx_payload
  } tx_state_t;

  tx_state_t         state;
  tx_state_t         state_nxt;
  // Flits still owed to the current packet
  logic [size_w-1:0] remain;
  logic [size_w-1:0] remain_nxt;

  // Bus data goes straight to the buffer
  assign fill.flit = wr_data;
  assign fill.last = (remain == size_w'(1));

  always_comb begin
    state_nxt  = state;
    remain_nxt = remain;
    wr_ack     = 1'b0;
    fill.valid = 1'b0;
    case (state)
      tx_idle: begin
        if (wr_en) begin
          // Size write, acked at once
          wr_ack     = 1'b1;
          remain_nxt = wr_data[size_w-1:0];
          // Empty packet leaves nothing to send
          if (wr_data[size_w-1:0] != '0) begin
            state_nxt = tx_first;
          end
        end
      end
      tx_first, tx_payload: begin
        fill.valid = wr_en;
        // Ack waits for buffer space
        wr_ack     = wr_en && fill.ready;
        if (wr_en && fill.ready) begin
          remain_nxt = remain - 1'b1;
          state_nxt  = (remain == size_w'(1)) ? tx_idle : tx_payload;
        end
      end
      default: state_nxt = tx_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= tx_idle;
      remain <= '0;
    end else begin
      state  <= state_nxt;
      remain <= remain_nxt;
    end
  end

endmodule

/* rtl/mpi_rx_reader.sv */
////////////////////////////////////////
// Ingress reader
// Serves packet size, then its flits,
// to bus reads
////////////////////////////////////////

`timescale 1ns/10ps

module mpi_rx_reader #(
  parameter int buf_depth = 16
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    rd_en,
  input  logic [mpi_pkg::size_w_f(buf_depth)-1:0] packet_size,
  output logic                                    rd_ack,
  output mpi_pkg::flit_t                          rd_data,
  noc_flit_if.sink                                drain
);
  import mpi_pkg::*;

  typedef enum logic {
    rx_idle,
    rx_flit
  } rx_state_t;

  rx_state_t state;
  rx_state_t state_nxt;

  always_comb begin
    state_nxt   = state;
    rd_ack      = 1'b0;
    rd_data     = '0;
    drain.ready = 1'b0;
    case (state)
      rx_idle: begin
        if (rd_en) begin
          rd_ack = 1'b1;
          // Size of the waiting packet, zero when none
          if (drain.valid) begin
            rd_data = flit_t'(packet_size);
            if (packet_size != '0) begin
              state_nxt = rx_flit;
            end
          end
        end
      end
      rx_flit: begin
        if (rd_en) begin
          // Each read pops one flit
          rd_ack      = 1'b1;
          rd_data     = drain.flit;
          drain.ready = 1'b1;
          if (packet_size == 1) begin
            state_nxt = rx_idle;
          end
        end
      end
      default: state_nxt = rx_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

/* rtl/mpi_ctrl_responder.sv */
////////////////////////////////////////
// Control message responder
// Strips control requests from ingress
// and merges replies between packets
////////////////////////////////////////

`timescale 1ns/10ps

module mpi_ctrl_responder (
  input  logic           clk,
  input  logic           rst,
  input  logic           enabled,
  input  mpi_pkg::flit_t noc_in_flit,
  input  logic           noc_in_last,
  input  logic           noc_in_valid,
  output logic           noc_in_ready,
  output mpi_pkg::flit_t noc_out_flit,
  output logic           noc_out_last,
  output logic           noc_out_valid,
  input  logic           noc_out_ready,
  noc_flit_if.source     rx_fill,
  noc_flit_if.sink       tx_drain
);
  import mpi_pkg::*;

  logic  pending;
  flit_t reply_flit;
  // Position trackers for both directions
  logic  rx_in_packet;
  logic  tx_in_packet;
  logic  is_req;
  logic  send_reply;
  flit_t reply_nxt;

  ////////////////////////////////////////
  // Ingress
  ////////////////////////////////////////

  // Single-flit request, only at a packet boundary
  assign is_req = !rx_in_packet && noc_in_last
               && (noc_in_flit[ctrl_class_lsb +: 3] == ctrl_class)
               && !noc_in_flit[ctrl_reply_bit];

  // Hold ingress while a reply is queued
  assign noc_in_ready  = !pending && rx_fill.ready;
  assign rx_fill.flit  = noc_in_flit;
  assign rx_fill.last  = noc_in_last;
  assign rx_fill.valid = noc_in_valid && !pending && !is_req;

  // Reply: swap source and destination, keep the middle bits
  always_comb begin
    reply_nxt                      = noc_in_flit;
    reply_nxt[ctrl_src_lsb +: 5]   = noc_in_flit[ctrl_dst_lsb +: 5];
    reply_nxt[ctrl_dst_lsb +: 5]   = noc_in_flit[ctrl_src_lsb +: 5];
    reply_nxt[ctrl_enable_bit]     = enabled;
    reply_nxt[ctrl_reply_bit]      = 1'b1;
  end

  ////////////////////////////////////////
  // Egress
  ////////////////////////////////////////

  // Reply only wins between egress packets
  assign send_reply     = pending && !tx_in_packet;
  assign noc_out_valid  = send_reply ? 1'b1 : tx_drain.valid;
  assign noc_out_flit   = send_reply ? reply_flit : tx_drain.flit;
  assign noc_out_last   = send_reply ? 1'b1 : tx_drain.last;
  assign tx_drain.ready = !send_reply && noc_out_ready;

  always_ff @(posedge clk) begin
    if (noc_in_valid && noc_in_ready && is_req) begin
      reply_flit <= reply_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending      <= 1'b0;
      rx_in_packet <= 1'b0;
      tx_in_packet <= 1'b0;
    end else begin
      if (noc_in_valid && noc_in_ready && is_req) begin
        pending <= 1'b1;
      end else if (send_reply && noc_out_ready) begin
        pending <= 1'b0;
      end
      if (rx_fill.valid && rx_fill.ready) begin
        rx_in_packet <= !noc_in_last;
      end
      if (tx_drain.valid && tx_drain.ready) begin
        tx_in_packet <= !tx_drain.last;
      end
    end
  end

endmodule

/* rtl/mpi_endpoint.sv */
////////////////////////////////////////
// MPI message endpoint, top level
// Bus slave with egress and ingress
// packet buffers and control replies
////////////////////////////////////////

`timescale 1ns/10ps

module mpi_endpoint #(
  parameter int buf_depth = 16
) (
  input  logic               clk,
  input  logic               rst,
  output mpi_pkg::flit_t     noc_out_flit,
  output logic               noc_out_last,
  output logic               noc_out_valid,
  input  logic               noc_out_ready,
  input  mpi_pkg::flit_t     noc_in_flit,
  input  logic               noc_in_last,
  input  logic               noc_in_valid,
  output logic               noc_in_ready,
  input  mpi_pkg::bus_addr_t bus_addr,
  input  logic               bus_we,
  input  logic               bus_en,
  input  mpi_pkg::flit_t     bus_data_in,
  output mpi_pkg::flit_t     bus_data_out,
  output logic               bus_ack,
  output logic               bus_err,
  output logic               irq
);
  import mpi_pkg::*;

  localparam int size_w = size_w_f(buf_depth);

  // Framer -> egress buffer -> responder
  noc_flit_if tx_fill ();
  noc_flit_if tx_drain ();
  // Responder -> ingress buffer -> reader
  noc_flit_if rx_fill ();
  noc_flit_if rx_drain ();

  logic              fifo_rd_en;
  logic              fifo_wr_en;
  logic              rd_ack;
  logic              wr_ack;
  flit_t             rd_data;
  logic              enabled;
  logic [size_w-1:0] rx_size;

  // Interrupt while a complete packet waits
  assign irq = rx_drain.valid;

  mpi_bus_regs u_bus_regs (
    .clk          (clk),
    .rst          (rst),
    .bus_addr     (bus_addr),
    .bus_we       (bus_we),
    .bus_en       (bus_en),
    .bus_data_out (bus_data_out),
    .bus_ack      (bus_ack),
    .bus_err      (bus_err),
    .fifo_rd_en   (fifo_rd_en),
    .fifo_wr_en   (fifo_wr_en),
    .rd_ack       (rd_ack),
    .rd_data      (rd_data),
    .wr_ack       (wr_ack),
    .tx_busy      (noc_out_valid),
    .rx_avail     (irq),
    .enabled      (enabled)
  );

  mpi_tx_framer #(.buf_depth(buf_depth)) u_tx_framer (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (fifo_wr_en),
    .wr_data (bus_data_in),
    .wr_ack  (wr_ack),
    .fill    (tx_fill.source)
  );

  // Egress size is not needed downstream
  mpi_packet_buffer #(.buf_depth(buf_depth)) u_tx_buffer (
    .clk         (clk),
    .rst         (rst),
    .fill        (tx_fill.sink),
    .drain       (tx_drain.source),
    .packet_size ()
  );

  mpi_ctrl_responder u_ctrl_responder (
    .clk           (clk),
    .rst           (rst),
    .enabled       (enabled),
    .noc_in_flit   (noc_in_flit),
    .noc_in_last   (noc_in_last),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_last  (noc_out_last),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .rx_fill       (rx_fill.source),
    .tx_drain      (tx_drain.sink)
  );

  mpi_packet_buffer #(.buf_depth(buf_depth)) u_rx_buffer (
    .clk         (clk),
    .rst         (rst),
    .fill        (rx_fill.sink),
    .drain       (rx_drain.source),
    .packet_size (rx_size)
  );

  mpi_rx_reader #(.buf_depth(buf_depth)) u_rx_reader (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (fifo_rd_en),
    .packet_size (rx_size),
    .rd_ack      (rd_ack),
    .rd_data     (rd_data),
    .drain       (rx_drain.sink)
  );

endmodule

/* bench/mpi_tb_tasks.svh */
////////////////////////////////////////
// MPI endpoint testbench helpers
// Bus and NoC drivers, output monitor,
// reply model and value check
////////////////////////////////////////

`ifndef MPI_TB_TASKS_SVH
`define MPI_TB_TASKS_SVH

// Compare and count, report on mismatch
task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
  end
endtask

// Expected reply: swap source and destination, report enable, mark as reply
function automatic flit_t ref_reply(input flit_t req, input logic en);
  flit_t r;
  r        = req;
  r[31:27] = req[23:19];
  r[23:19] = req[31:27];
  r[1]     = en;
  r[0]     = 1'b1;
  return r;
endfunction

// One bus access, held until ack or err
task automatic bus_access(input logic we, input bus_addr_t addr, input flit_t wdata,
                          output flit_t rdata, output logic acked, output logic erred);
  bus_en      = 1'b1;
  bus_we      = we;
  bus_addr    = addr;
  bus_data_in = wdata;
  @(negedge clk);
  while (!bus_ack && !bus_err) begin
    @(negedge clk);
  end
  rdata = bus_data_out;
  acked = bus_ack;
  erred = bus_err;
  // Access completes on this edge
  @(posedge clk);
  #drive_delay;
  bus_en = 1'b0;
  bus_we = 1'b0;
endtask

task automatic bus_write(input bus_addr_t addr, input flit_t data);
  flit_t rdata;
  logic  acked;
  logic  erred;
  bus_access(1'b1, addr, data, rdata, acked, erred);
  if (!acked) begin
    errors++;
    $display("Bus write to %h was answered with an error", addr);
  end
endtask

task automatic bus_read(input bus_addr_t addr, output flit_t data);
  logic acked;
  logic erred;
  bus_access(1'b0, addr, '0, data, acked, erred);
  if (!acked) begin
    errors++;
    $display("Bus read from %h was answered with an error", addr);
  end
endtask

// Offer one flit on noc_in until taken
task automatic send_noc_flit(input flit_t f, input logic l);
  noc_in_flit  = f;
  noc_in_last  = l;
  noc_in_valid = 1'b1;
  @(negedge clk);
  while (!noc_in_ready) begin
    @(negedge clk);
  end
  @(posedge clk);
  #drive_delay;
  noc_in_valid = 1'b0;
  noc_in_last  = 1'b0;
endtask

// Wait until every expected egress flit and reply was seen
task automatic wait_out_drained();
  while (exp_tx_flit.size() != 0 || exp_reply.size() != 0) begin
    @(negedge clk);
  end
  @(posedge clk);
  #drive_delay;
endtask

////////////////////////////////////////
// noc_out monitor
////////////////////////////////////////

// Sampled mid-cycle, a transfer happens on the next rising edge
initial begin
  flit_t exp;
  wait (!rst);
  forever begin
    @(negedge clk);
    if (noc_out_valid && noc_out_ready) begin
      // Class 111 with bit 0 set marks a reply
      if (noc_out_flit[26:24] == 3'b111 && noc_out_flit[0]) begin
        if (out_mid_packet) begin
          errors++;
          $display("Reply %h was sent inside an egress packet", noc_out_flit);
        end
        if (exp_reply.size() == 0) begin
          errors++;
          $display("Unexpected reply %h on noc_out", noc_out_flit);
        end else begin
          exp = exp_reply.pop_front();
          check("reply flit", exp, noc_out_flit);
          check("reply last", 1, noc_out_last);
        end
      end else if (exp_tx_flit.size() == 0) begin
        errors++;
        $display("Unexpected egress flit %h on noc_out", noc_out_flit);
      end else begin
        exp = exp_tx_flit.pop_front();
        check("egress flit", exp, noc_out_flit);
        check("egress last", exp_tx_last.pop_front(), noc_out_last);
        out_mid_packet = !noc_out_last;
      end
    end
  end
end

`endif

/* bench/tb_mpi_endpoint.sv */
////////////////////////////////////////
// MPI endpoint testbench
// Bus access, egress, ingress, control
// replies and error responses
////////////////////////////////////////

`timescale 1ns/10ps

module tb_mpi_endpoint;
  import mpi_pkg::*;

  localparam int buf_depth       = 16;
  localparam int tx_packets      = 5;
  localparam int drive_delay     = 10;
  localparam int cycles_per_flit = 200;

  logic      clk;
  logic      rst;
  flit_t     noc_out_flit;
  logic      noc_out_last;
  logic      noc_out_valid;
  logic      noc_out_ready;
  flit_t     noc_in_flit;
  logic      noc_in_last;
  logic      noc_in_valid;
  logic      noc_in_ready;
  bus_addr_t bus_addr;
  logic      bus_we;
  logic      bus_en;
  flit_t     bus_data_in;
  flit_t     bus_data_out;
  logic      bus_ack;
  logic      bus_err;
  logic      irq;

  integer seed;
  int     errors;
  int     checks;
  int     limit_cycles;
  logic   ready_random;
  logic   out_mid_packet;
  // Expected noc_out traffic
  flit_t  exp_tx_flit[$];
  logic   exp_tx_last[$];
  flit_t  exp_reply[$];
  // Stimulus drawn at time 0
  flit_t  tx_flits[$];
  int     tx_sizes[$];
  flit_t  rx_flits[$];
  flit_t  req_flits[2];

  `include "mpi_tb_tasks.svh"

  mpi_endpoint #(.buf_depth(buf_depth)) u_mpi_endpoint (
    .clk           (clk),
    .rst           (rst),
    .noc_out_flit  (noc_out_flit),
    .noc_out_last  (noc_out_last),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .noc_in_flit   (noc_in_flit),
    .noc_in_last   (noc_in_last),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .bus_addr      (bus_addr),
    .bus_we        (bus_we),
    .bus_en        (bus_en),
    .bus_data_in   (bus_data_in),
    .bus_data_out  (bus_data_out),
    .bus_ack       (bus_ack),
    .bus_err       (bus_err),
    .irq           (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Random egress back-pressure while enabled
  initial begin
    forever begin
      @(posedge clk);
      #drive_delay;
      noc_out_ready = ready_random ? 1'($random(seed)) : 1'b1;
    end
  end

  // Watchdog budget scales with the flit count
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    flit_t rdata;
    logic  acked;
    logic  erred;
    int    size;
    int    pos;
    flit_t f;
    rst            = 1'b1;
    bus_addr       = '0;
    bus_we         = 1'b0;
    bus_en         = 1'b0;
    bus_data_in    = '0;
    noc_in_flit    = '0;
    noc_in_last    = 1'b0;
    noc_in_valid   = 1'b0;
    noc_out_ready  = 1'b0;
    ready_random   = 1'b0;
    out_mid_packet = 1'b0;
    errors         = 0;
    checks         = 0;
    seed           = 32'h4905f554;

    // Egress packets keep bit 26 clear so none looks like a control flit
    for (int p = 0; p < tx_packets; p++) begin
      size = 1 + int'($unsigned($random(seed)) % buf_depth);
      tx_sizes.push_back(size);
      for (int i = 0; i < size; i++) begin
        f     = $random(seed);
        f[26] = 1'b0;
        tx_flits.push_back(f);
      end
    end
    size = 1 + int'($unsigned($random(seed)) % buf_depth);
    for (int i = 0; i < size; i++) begin
      f     = $random(seed);
      f[26] = 1'b0;
      rx_flits.push_back(f);
    end
    // Control requests carry class 111 and a clear bit 0
    for (int k = 0; k < 2; k++) begin
      f         = $random(seed);
      f[26:24]  = 3'b111;
      f[0]      = 1'b0;
      req_flits[k] = f;
    end
    limit_cycles = (tx_flits.size() + rx_flits.size() + 2 + 20) * cycles_per_flit;

    repeat (5) @(posedge clk);
    #drive_delay;
    rst = 1'b0;

    ////////////////////////////////////////
    // Reset state and bad addresses
    ////////////////////////////////////////
    check("irq after reset", 0, irq);
    check("noc_in_ready after reset", 1, noc_in_ready);
    bus_read(32'h4, rdata);
    check("status after reset", 0, rdata);
    bus_read(32'h0, rdata);
    check("empty fifo read", 0, rdata);
    bus_access(1'b1, 32'h8, 32'hffff_ffff, rdata, acked, erred);
    check("write 0x8 err", 1, erred);
    check("write 0x8 ack", 0, acked);
    bus_access(1'b0, 32'h8, '0, rdata, acked, erred);
    check("read 0x8 err", 1, erred);
    check("read 0x8 ack", 0, acked);
    bus_read(32'h4, rdata);
    check("status after bad access", 0, rdata);

    ////////////////////////////////////////
    // Egress with a request while disabled
    ////////////////////////////////////////
    ready_random = 1'b1;
    fork
      begin
        pos = 0;
        for (int p = 0; p < tx_packets; p++) begin
          bus_write(32'h0, flit_t'(tx_sizes[p]));
          for (int i = 0; i < tx_sizes[p]; i++) begin
            exp_tx_flit.push_back(tx_flits[pos]);
            exp_tx_last.push_back(i == tx_sizes[p] - 1);
            bus_write(32'h0, tx_flits[pos]);
            pos++;
          end
        end
      end
      begin
        repeat (40) @(posedge clk);
        #drive_delay;
        exp_reply.push_back(ref_reply(req_flits[0], 1'b0));
        send_noc_flit(req_flits[0], 1'b1);
      end
    join
    wait_out_drained();
    // Request must not reach the ingress buffer
    check("irq after request", 0, irq);

    ////////////////////////////////////////
    // Ingress packet read back over the bus
    ////////////////////////////////////////
    ready_random = 1'b0;
    for (int i = 0; i < rx_flits.size(); i++) begin
      send_noc_flit(rx_flits[i], i == rx_flits.size() - 1);
    end
    @(negedge clk);
    while (!irq) begin
      @(negedge clk);
    end
    @(posedge clk);
    #drive_delay;
    bus_read(32'h4, rdata);
    check("status with packet", 1, rdata);
    bus_read(32'h0, rdata);
    check("ingress size", rx_flits.size(), rdata);
    for (int i = 0; i < rx_flits.size(); i++) begin
      bus_read(32'h0, rdata);
      check("ingress flit", rx_flits[i], rdata);
    end
    check("irq after last read", 0, irq);

    ////////////////////////////////////////
    // Enable, then a second request
    ////////////////////////////////////////
    bus_write(32'h4, 32'h1);
    exp_reply.push_back(ref_reply(req_flits[1], 1'b1));
    send_noc_flit(req_flits[1], 1'b1);
    // Ingress stalls while the reply is pending
    check("noc_in_ready with reply pending", 0, noc_in_ready);
    wait_out_drained();
    check("noc_in_ready after reply", 1, noc_in_ready);
    bus_read(32'h0, rdata);
    check("fifo read after request", 0, rdata);
    check("irq after second request", 0, irq);
    bus_read(32'h4, rdata);
    check("final status", 0, rdata);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+bench
rtl/mpi_pkg.sv
rtl/noc_flit_if.sv
rtl/mpi_packet_buffer.sv
rtl/mpi_bus_regs.sv
rtl/mpi_tx_framer.sv
rtl/mpi_rx_reader.sv
rtl/mpi_ctrl_responder.sv
rtl/mpi_endpoint.sv
bench/tb_mpi_endpoint.sv

/* Makefile */
# Verilator flow for the MPI endpoint

VERILATOR ?= verilator
TOP       ?= tb_mpi_endpoint
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(wildcard rtl/*.sv) $(wildcard bench/*.sv bench/*.svh)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
